// ==== flist.f ====
+incdir+testbench
src/rv_core_pkg.sv
src/imem_fetch.sv
src/qed_dup.sv
src/inst_decode.sv
src/regfile.sv
src/alu.sv
src/qed_commit_check.sv
src/rv_pipeline_top.sv
testbench/tb_top.sv

// ==== src/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import rv_core_pkg::*; (
    input  wire [ALU_OP_WIDTH-1:0] op,
    input  wire [XLEN-1:0]         in1,
    input  wire [XLEN-1:0]         in2,
    output logic [XLEN-1:0]        out
);

    // shift amount from low bits of the second operand
    logic [4:0] shamt;

    assign shamt = in2[4:0];

    always_comb begin
        case (op)
            ALU_ADD: out = in1 + in2;
            ALU_SUB: out = in1 - in2;
            ALU_SLL: out = in1 << shamt;
            // compares give 0 or 1
            ALU_SLT: begin
                out = {{(XLEN-1){1'b0}}, $signed(in1) < $signed(in2)};
            end
            ALU_SLTU: begin
                out = {{(XLEN-1){1'b0}}, in1 < in2};
            end
            ALU_XOR: out = in1 ^ in2;
            ALU_SRL: out = in1 >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA: out = $unsigned($signed(in1) >>> shamt);
            ALU_OR:  out = in1 | in2;
            ALU_AND: out = in1 & in2;
            // unused codes
            default: out = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/imem_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module imem_fetch import rv_core_pkg::*; (
    input  wire              clk,
    input  wire              reset,
    input  wire              fetch_hold,
    input  wire              imem_ack,
    input  wire [XLEN-1:0]   imem_dat,
    output logic             imem_cyc,
    output logic             imem_stb,
    output logic [XLEN-1:0]  imem_adr,
    output logic             fetch_valid,
    output inst_word_t       fetch_inst
);

    // program counter, only ever steps forward
    logic [XLEN-1:0] pc;
    // set one edge after reset, then stays up
    logic            run;

    always_ff @(posedge clk) begin
        if (reset) begin
            run <= 1'b0;
            pc  <= RESET_PC;
        end else begin
            run <= 1'b1;
            // next word once the slave has acked
            if (fetch_valid) begin
                pc <= pc + XLEN'(4);
            end
        end
    end

    // back-to-back reads
    // one idle cycle while a duplicate goes out
    assign imem_cyc = run && !fetch_hold;
    assign imem_stb = run && !fetch_hold;
    assign imem_adr = pc;

    // transfer ends on stb and ack together
    assign fetch_valid = imem_stb && imem_ack;
    assign fetch_inst  = imem_dat;

    a_stb_in_cycle: assert property (@(posedge clk) disable iff (reset)
        imem_stb |-> imem_cyc);

    // a stalled request keeps its address and stays up
    a_adr_stable: assert property (@(posedge clk) disable iff (reset)
        imem_stb && !imem_ack |=> imem_stb && $stable(imem_adr));

endmodule

`default_nettype wire

// ==== src/inst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decode import rv_core_pkg::*; (
    input  wire inst_word_t           inst,
    output logic [ALU_OP_WIDTH-1:0]   alu_op,
    output logic                      use_imm,
    output logic [XLEN-1:0]           imm,
    output logic [REG_ADDR_WIDTH-1:0] rs1_addr,
    output logic [REG_ADDR_WIDTH-1:0] rs2_addr,
    output logic [REG_ADDR_WIDTH-1:0] rd_addr,
    output logic                      wr_reg
);

    // kept opcode with legal function bits
    logic legal;
    // upper seven bits of either view
    logic f7_zero;
    logic f7_alt;

    // funct3 plus alternate bit to ALU operation, same for both groups
    function automatic logic [ALU_OP_WIDTH-1:0] alu_sel(
        input logic [2:0] funct3,
        input logic       alt
    );
        logic [ALU_OP_WIDTH-1:0] sel;
        case (funct3)
            FUNCT3_ADD_SUB: sel = alt ? ALU_SUB : ALU_ADD;
            FUNCT3_SLL:     sel = ALU_SLL;
            FUNCT3_SLT:     sel = ALU_SLT;
            FUNCT3_SLTU:    sel = ALU_SLTU;
            FUNCT3_XOR:     sel = ALU_XOR;
            FUNCT3_SRL_SRA: sel = alt ? ALU_SRA : ALU_SRL;
            FUNCT3_OR:      sel = ALU_OR;
            default:        sel = ALU_AND;
        endcase
        return sel;
    endfunction

    assign f7_zero = (inst.r.funct7 == 7'b0);
    assign f7_alt  = (inst.r.funct7 == FUNCT7_ALT);

    // sign-extended I-type immediate, shifts only look at the low five bits
    assign imm = {{(XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};

    always_comb begin
        alu_op   = ALU_ADD;
        use_imm  = 1'b0;
        legal    = 1'b0;
        rs1_addr = inst.r.rs1;
        rs2_addr = '0;
        rd_addr  = inst.r.rd;
        case (inst.r.opcode)
            OPCODE_OP: begin
                rs2_addr = inst.r.rs2;
                alu_op   = alu_sel(inst.r.funct3, f7_alt);
                // alternate form only for sub and sra
                legal    = f7_zero || (f7_alt &&
                           (inst.r.funct3 == FUNCT3_ADD_SUB ||
                            inst.r.funct3 == FUNCT3_SRL_SRA));
            end
            OPCODE_OP_IMM: begin
                use_imm  = 1'b1;
                rs1_addr = inst.i.rs1;
                rd_addr  = inst.i.rd;
                // no subi, so alt only matters for srai
                alu_op   = alu_sel(inst.i.funct3,
                                   f7_alt && inst.i.funct3 == FUNCT3_SRL_SRA);
                case (inst.i.funct3)
                    FUNCT3_SLL:     legal = f7_zero;
                    FUNCT3_SRL_SRA: legal = f7_zero || f7_alt;
                    default:        legal = 1'b1;
                endcase
            end
            default: begin
                // lui, auipc and everything else retire as bubbles
                legal = 1'b0;
            end
        endcase
    end

    // x0 destinations never reach writeback
    assign wr_reg = legal && (rd_addr != '0);

endmodule

`default_nettype wire

// ==== src/qed_commit_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module qed_commit_check import rv_core_pkg::*; (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      qed_mode,
    input  wire                      commit_valid,
    input  wire [REG_ADDR_WIDTH-1:0] commit_rd,
    output logic                     chk_en
);

    logic [COMMIT_CNT_WIDTH-1:0] orig_cnt;
    logic [COMMIT_CNT_WIDTH-1:0] dup_cnt;
    // rd 1..15 is an original, rd 16..31 a duplicate
    logic                        orig_commit;
    logic                        dup_commit;

    assign orig_commit = commit_valid && commit_rd != '0 && !commit_rd[QED_SHADOW_BIT];
    assign dup_commit  = commit_valid && commit_rd[QED_SHADOW_BIT];

    // counters wrap, only equality matters
    always_ff @(posedge clk) begin
        if (reset || !qed_mode) begin
            orig_cnt <= '0;
            dup_cnt  <= '0;
        end else begin
            orig_cnt <= orig_cnt + COMMIT_CNT_WIDTH'(orig_commit);
            dup_cnt  <= dup_cnt + COMMIT_CNT_WIDTH'(dup_commit);
        end
    end

    // both streams have retired the same work
    assign chk_en = qed_mode && (orig_cnt == dup_cnt);

endmodule

`default_nettype wire

// ==== src/qed_dup.sv ====
`timescale 1ns/1ps
`default_nettype none

module qed_dup import rv_core_pkg::*; (
    input  wire              clk,
    input  wire              reset,
    input  wire              qed_mode,
    input  wire              fetch_valid,
    input  wire inst_word_t  fetch_inst,
    output logic             fetch_hold,
    output logic             issue_valid,
    output inst_word_t       issue_inst,
    output logic             issue_is_dup
);

    // duplicate waiting for its slot
    logic       dup_pending;
    inst_word_t dup_inst;

    // move a register index into the upper half, x0 stays x0
    function automatic logic [REG_ADDR_WIDTH-1:0] shadow_reg(
        input logic [REG_ADDR_WIDTH-1:0] idx
    );
        logic [REG_ADDR_WIDTH-1:0] res;
        res = idx;
        if (idx != '0) begin
            res[QED_SHADOW_BIT] = 1'b1;
        end
        return res;
    endfunction

    function automatic inst_word_t make_dup(input inst_word_t orig);
        inst_word_t dup;
        dup       = orig;
        dup.r.rd  = shadow_reg(orig.r.rd);
        dup.r.rs1 = shadow_reg(orig.r.rs1);
        // rs2 field is immediate bits outside R-type
        if (orig.r.opcode == OPCODE_OP) begin
            dup.r.rs2 = shadow_reg(orig.r.rs2);
        end
        return dup;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            dup_pending <= 1'b0;
        end else begin
            dup_pending <= qed_mode && fetch_valid;
        end
    end

    // captured from every original
    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            dup_inst <= make_dup(fetch_inst);
        end
    end

    // fetch idles while the duplicate issues
    assign fetch_hold   = dup_pending;
    assign issue_valid  = fetch_valid || dup_pending;
    assign issue_inst   = dup_pending ? dup_inst : fetch_inst;
    assign issue_is_dup = dup_pending;

    a_dup_rd_shadow: assert property (@(posedge clk) disable iff (reset)
        issue_valid && issue_is_dup |->
            issue_inst.r.rd == '0 || issue_inst.r.rd[QED_SHADOW_BIT]);

    // fetch has to honor the hold, so the two never collide
    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        dup_pending |-> !fetch_valid);

endmodule

`default_nettype wire

// ==== src/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile import rv_core_pkg::*; (
    input  wire                      clk,
    input  wire [REG_ADDR_WIDTH-1:0] ra1,
    input  wire [REG_ADDR_WIDTH-1:0] ra2,
    output logic [XLEN-1:0]          rd1,
    output logic [XLEN-1:0]          rd2,
    input  wire                      wen,
    input  wire [REG_ADDR_WIDTH-1:0] wa,
    input  wire [XLEN-1:0]           wd
);

    // x1..x31, x0 has no storage
    logic [XLEN-1:0] regs [1:(2**REG_ADDR_WIDTH)-1];

    always_ff @(posedge clk) begin
        if (wen && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // combinational reads
    // same-cycle write is covered by the bypass upstream
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

    // decode filters x0 before writeback
    a_no_x0_write: assert property (@(posedge clk)
        wen |-> wa != '0);

endmodule

`default_nettype wire

// ==== src/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    // datapath and register index widths
    localparam int XLEN           = 32;
    localparam int REG_ADDR_WIDTH = 5;
    // x16..x31 belong to the duplicate stream
    localparam int QED_SHADOW_BIT = 4;

    // first fetch address
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0200;
    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;

    // major opcodes that are executed
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

    // funct3 values, shared by both ALU groups
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;
    // sub and sra
    localparam logic [6:0] FUNCT7_ALT     = 7'b0100000;

    // ALU operation codes
    localparam int ALU_OP_WIDTH = 4;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SLL  = 4'd2;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SLT  = 4'd3;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SLTU = 4'd4;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_XOR  = 4'd5;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SRL  = 4'd6;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SRA  = 4'd7;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_OR   = 4'd8;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_AND  = 4'd9;

    // original and duplicate commit counters
    localparam int COMMIT_CNT_WIDTH = 5;

    // one instruction word, seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [6:0]                funct7;
            logic [REG_ADDR_WIDTH-1:0] rs2;
            logic [REG_ADDR_WIDTH-1:0] rs1;
            logic [2:0]                funct3;
            logic [REG_ADDR_WIDTH-1:0] rd;
            logic [6:0]                opcode;
        } r;
        struct packed {
            logic [11:0]               imm12;
            logic [REG_ADDR_WIDTH-1:0] rs1;
            logic [2:0]                funct3;
            logic [REG_ADDR_WIDTH-1:0] rd;
            logic [6:0]                opcode;
        } i;
    } inst_word_t;

endpackage

`default_nettype wire

// ==== src/rv_pipeline_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_pipeline_top import rv_core_pkg::*; (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       qed_mode,
    output logic                      imem_cyc,
    output logic                      imem_stb,
    output logic [XLEN-1:0]           imem_adr,
    input  wire                       imem_ack,
    input  wire [XLEN-1:0]            imem_dat,
    output logic                      commit_valid,
    output logic [REG_ADDR_WIDTH-1:0] commit_rd,
    output logic [XLEN-1:0]           commit_data,
    output logic                      chk_en
);

    // fetch to qed
    logic                      fetch_hold;
    logic                      fetch_valid;
    inst_word_t                fetch_inst;
    // qed to decode/execute
    logic                      issue_valid;
    inst_word_t                issue_inst;
    logic                      issue_is_dup;
    // decode/execute stage
    inst_word_t                dx_inst;
    logic                      dx_is_dup;
    logic [ALU_OP_WIDTH-1:0]   alu_op;
    logic                      use_imm;
    logic [XLEN-1:0]           imm;
    logic [REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [REG_ADDR_WIDTH-1:0] rs2_addr;
    logic [REG_ADDR_WIDTH-1:0] rd_addr;
    logic                      wr_reg;
    logic [XLEN-1:0]           rs1_data;
    logic [XLEN-1:0]           rs2_data;
    logic [XLEN-1:0]           rs1_byp;
    logic [XLEN-1:0]           rs2_byp;
    logic [XLEN-1:0]           alu_in2;
    logic [XLEN-1:0]           alu_out;
    // writeback stage
    logic                      wb_wr;
    logic [REG_ADDR_WIDTH-1:0] wb_rd;
    logic [XLEN-1:0]           wb_data;

    imem_fetch i_imem_fetch (
        .clk         (clk),
        .reset       (reset),
        .fetch_hold  (fetch_hold),
        .imem_ack    (imem_ack),
        .imem_dat    (imem_dat),
        .imem_cyc    (imem_cyc),
        .imem_stb    (imem_stb),
        .imem_adr    (imem_adr),
        .fetch_valid (fetch_valid),
        .fetch_inst  (fetch_inst)
    );

    qed_dup i_qed_dup (
        .clk          (clk),
        .reset        (reset),
        .qed_mode     (qed_mode),
        .fetch_valid  (fetch_valid),
        .fetch_inst   (fetch_inst),
        .fetch_hold   (fetch_hold),
        .issue_valid  (issue_valid),
        .issue_inst   (issue_inst),
        .issue_is_dup (issue_is_dup)
    );

    // empty issue slot becomes a nop, nothing stalls
    always_ff @(posedge clk) begin
        if (reset) begin
            dx_inst   <= NOP_INST;
            dx_is_dup <= 1'b0;
        end else begin
            dx_inst   <= issue_valid ? issue_inst : inst_word_t'(NOP_INST);
            dx_is_dup <= issue_valid && issue_is_dup;
        end
    end

    inst_decode i_inst_decode (
        .inst     (dx_inst),
        .alu_op   (alu_op),
        .use_imm  (use_imm),
        .imm      (imm),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr),
        .wr_reg   (wr_reg)
    );

    regfile i_regfile (
        .clk (clk),
        .ra1 (rs1_addr),
        .ra2 (rs2_addr),
        .rd1 (rs1_data),
        .rd2 (rs2_data),
        .wen (wb_wr),
        .wa  (wb_rd),
        .wd  (wb_data)
    );

    // writeback result overrides a stale regfile read
    assign rs1_byp = (wb_wr && wb_rd == rs1_addr && rs1_addr != '0) ? wb_data : rs1_data;
    assign rs2_byp = (wb_wr && wb_rd == rs2_addr && rs2_addr != '0) ? wb_data : rs2_data;
    assign alu_in2 = use_imm ? imm : rs2_byp;

    alu i_alu (
        .op  (alu_op),
        .in1 (rs1_byp),
        .in2 (alu_in2),
        .out (alu_out)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_wr <= 1'b0;
        end else begin
            wb_wr <= wr_reg;
        end
    end

    // result and destination, no reset needed
    always_ff @(posedge clk) begin
        wb_rd   <= rd_addr;
        wb_data <= alu_out;
    end

    // commit trace straight from writeback
    assign commit_valid = wb_wr;
    assign commit_rd    = wb_rd;
    assign commit_data  = wb_data;

    qed_commit_check i_qed_commit_check (
        .clk          (clk),
        .reset        (reset),
        .qed_mode     (qed_mode),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .chk_en       (chk_en)
    );

    // a duplicate that writes must land in the shadow half
    a_dup_writes_shadow: assert property (@(posedge clk) disable iff (reset)
        dx_is_dup && wr_reg |-> rd_addr[QED_SHADOW_BIT]);

endmodule

`default_nettype wire

// ==== testbench/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

`default_nettype none

import rv_core_pkg::*;

// register-register word
function automatic logic [31:0] r_type_word(
    input logic [6:0] funct7,
    input logic [4:0] rs2,
    input logic [4:0] rs1,
    input logic [2:0] funct3,
    input logic [4:0] rd
);
    return {funct7, rs2, rs1, funct3, rd, OPCODE_OP};
endfunction

// register-immediate word
function automatic logic [31:0] i_type_word(
    input logic [11:0] imm,
    input logic [4:0]  rs1,
    input logic [2:0]  funct3,
    input logic [4:0]  rd
);
    return {imm, rs1, funct3, rd, OPCODE_OP_IMM};
endfunction

// random legal ALU op, sources often taken from the previous destination
function automatic logic [31:0] pick_alu_inst(input int reg_limit, input logic [4:0] prev_rd);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  funct3;
    logic [11:0] imm;
    logic        alt;
    rd     = 5'(1 + $urandom % (reg_limit - 1));
    rs1    = ($urandom % 2 == 0) ? prev_rd : 5'($urandom % reg_limit);
    rs2    = ($urandom % 2 == 0) ? prev_rd : 5'($urandom % reg_limit);
    funct3 = 3'($urandom % 8);
    imm    = 12'($urandom);
    alt    = ($urandom % 2 == 1);
    if ($urandom % 2 == 0) begin
        // only sub and sra have an alternate form
        alt = alt && (funct3 == FUNCT3_ADD_SUB || funct3 == FUNCT3_SRL_SRA);
        return r_type_word(alt ? FUNCT7_ALT : 7'b0, rs2, rs1, funct3, rd);
    end
    // shift immediates keep funct7 in the upper bits
    if (funct3 == FUNCT3_SLL || funct3 == FUNCT3_SRL_SRA) begin
        alt = alt && (funct3 == FUNCT3_SRL_SRA);
        imm = {alt ? FUNCT7_ALT : 7'b0, imm[4:0]};
    end
    return i_type_word(imm, rs1, funct3, rd);
endfunction

// words that must retire without a commit
function automatic logic [31:0] make_bubble(input int reg_limit);
    logic [4:0] rd;
    rd = 5'(1 + $urandom % (reg_limit - 1));
    case ($urandom % 4)
        // lui
        0: return {20'($urandom), rd, 7'b0110111};
        // auipc
        1: return {20'($urandom), rd, 7'b0010111};
        // mul, not part of the kept groups
        2: return r_type_word(7'b0000001, 5'd2, 5'd1, FUNCT3_ADD_SUB, rd);
        default: return i_type_word(12'($urandom), 5'($urandom % reg_limit), FUNCT3_XOR, 5'd0);
    endcase
endfunction

// ISA result of one word, wr low when it retires as a bubble
function automatic logic [31:0] golden_exec(
    input  logic [31:0] inst,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic        wr
);
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic        imm_form;
    logic [31:0] opb;
    logic [4:0]  sh;
    logic [31:0] res;
    opcode   = inst[6:0];
    funct3   = inst[14:12];
    funct7   = inst[31:25];
    imm_form = (opcode == OPCODE_OP_IMM);
    opb      = imm_form ? {{20{inst[31]}}, inst[31:20]} : b;
    sh       = opb[4:0];
    wr       = (opcode == OPCODE_OP || imm_form) && inst[11:7] != 5'd0;
    case (funct3)
        3'b000: res = (!imm_form && funct7 == 7'h20) ? a - opb : a + opb;
        3'b001: res = a << sh;
        3'b010: res = {31'b0, $signed(a) < $signed(opb)};
        3'b011: res = {31'b0, a < opb};
        3'b100: res = a ^ opb;
        3'b101: begin
            if (funct7 == 7'h20) begin
                res = $signed(a) >>> sh;
            end else begin
                res = a >> sh;
            end
        end
        3'b110: res = a | opb;
        default: res = a & opb;
    endcase
    // funct7 is free for the non-shift immediates only
    if (!imm_form || funct3 == 3'b001 || funct3 == 3'b101) begin
        if (funct7 != 7'h0 && !(funct7 == 7'h20 &&
            (funct3 == 3'b101 || (!imm_form && funct3 == 3'b000)))) begin
            wr = 1'b0;
        end
    end
    return res;
endfunction

`default_nettype wire

`endif

// ==== testbench/tb_top.sv ====
`timescale 1ns/1ps
`include "tb_model.svh"
`default_nettype none

module tb_top import rv_core_pkg::*; ();

    // body lengths per phase, init words come on top
    localparam int ALU_BODY    = 120;
    localparam int BUBBLE_BODY = 60;
    localparam int QED_BODY    = 80;
    localparam int TOTAL_INST  = (31 + ALU_BODY) + (31 + BUBBLE_BODY) + (15 + QED_BODY);
    localparam int CYCLE_LIMIT = 8 * TOTAL_INST + 200;
    localparam int PROG_MAX    = 160;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      qed_mode;
    logic                      imem_cyc;
    logic                      imem_stb;
    logic [XLEN-1:0]           imem_adr;
    logic                      imem_ack;
    logic [XLEN-1:0]           imem_dat;
    logic                      commit_valid;
    logic [REG_ADDR_WIDTH-1:0] commit_rd;
    logic [XLEN-1:0]           commit_data;
    logic                      chk_en;

    // instruction memory contents and slave state
    logic [XLEN-1:0]           prog [0:PROG_MAX-1];
    int                        prog_len = 0;
    logic                      in_xfer = 1'b0;
    logic                      xfer_done;
    int                        wait_left = 0;
    // golden state and expected commit pipeline
    logic [XLEN-1:0]           gold_regs [0:31];
    logic                      stage_a_v;
    logic [4:0]                stage_a_rd;
    logic [XLEN-1:0]           stage_a_data;
    logic                      a_is_orig;
    logic                      exp_valid;
    logic [4:0]                exp_rd;
    logic [XLEN-1:0]           exp_data;
    logic [XLEN-1:0]           exp_adr;
    logic [XLEN-1:0]           last_adr;
    int                        accept_count = 0;
    int                        cycle_count = 0;
    string                     test_name = "reset";

    rv_pipeline_top i_rv_pipeline_top (
        .clk          (clk),
        .reset        (reset),
        .qed_mode     (qed_mode),
        .imem_cyc     (imem_cyc),
        .imem_stb     (imem_stb),
        .imem_adr     (imem_adr),
        .imem_ack     (imem_ack),
        .imem_dat     (imem_dat),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .chk_en       (chk_en)
    );

    always #10 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [XLEN-1:0] program_word(input logic [XLEN-1:0] adr);
        logic [XLEN-1:0] idx;
        idx = (adr - RESET_PC) >> 2;
        if (adr >= RESET_PC && idx < prog_len) begin
            return prog[idx];
        end
        // past the end the core runs on nops
        return NOP_INST;
    endfunction

    // Wishbone slave, 0..3 wait cycles per transfer
    always @(posedge clk) begin
        xfer_done = (imem_stb === 1'b1) && (imem_ack === 1'b1);
        #1;
        if (imem_stb !== 1'b1) begin
            in_xfer  = 1'b0;
            imem_ack = 1'b0;
        end else begin
            // new request, draw its latency
            if (!in_xfer || xfer_done) begin
                in_xfer   = 1'b1;
                wait_left = $urandom % 4;
            end
            if (wait_left == 0) begin
                imem_ack = 1'b1;
                imem_dat = program_word(imem_adr);
            end else begin
                imem_ack  = 1'b0;
                wait_left = wait_left - 1;
            end
        end
    end

    // golden model retires in fetch order, commit due two edges after accept
    always @(posedge clk) begin : expect_chain
        logic [XLEN-1:0] result;
        logic            wr;
        last_adr <= imem_adr;
        if (reset) begin
            stage_a_v    <= 1'b0;
            a_is_orig    <= 1'b0;
            exp_valid    <= 1'b0;
            exp_adr      <= RESET_PC;
            accept_count <= 0;
        end else begin
            exp_valid    <= stage_a_v;
            exp_rd       <= stage_a_rd;
            exp_data     <= stage_a_data;
            if (imem_stb && imem_ack) begin
                result = golden_exec(imem_dat, gold_regs[imem_dat[19:15]],
                                     gold_regs[imem_dat[24:20]], wr);
                if (wr) begin
                    gold_regs[imem_dat[11:7]] = result;
                end
                stage_a_v    <= wr;
                stage_a_rd   <= imem_dat[11:7];
                stage_a_data <= result;
                a_is_orig    <= 1'b1;
                exp_adr      <= exp_adr + 32'd4;
                accept_count <= accept_count + 1;
            end else if (qed_mode && a_is_orig) begin
                // duplicate one cycle behind, shadow register, same data
                stage_a_rd <= stage_a_rd + 5'd16;
                a_is_orig  <= 1'b0;
            end else begin
                stage_a_v <= 1'b0;
                a_is_orig <= 1'b0;
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            stop_on_error($sformatf("timeout: run did not finish in %0d cycles", CYCLE_LIMIT));
        end
    end

    // quiet bus and trace during reset and the cycle after release
    a_reset_quiet: assert property (@(posedge clk)
        reset ##1 reset |-> !imem_stb && !commit_valid)
        else stop_on_error($sformatf("mismatch reset stb/commit: expected 0/0 actual %b/%b",
                                     $sampled(imem_stb), $sampled(commit_valid)));
    a_release_quiet: assert property (@(posedge clk)
        $fell(reset) |-> !imem_stb && !commit_valid)
        else stop_on_error($sformatf("mismatch reset stb/commit: expected 0/0 actual %b/%b",
                                     $sampled(imem_stb), $sampled(commit_valid)));
    a_first_adr: assert property (@(posedge clk)
        $fell(reset) |=> imem_stb && imem_adr == RESET_PC)
        else stop_on_error($sformatf("mismatch %s first adr: expected %h actual %h",
                                     test_name, RESET_PC, $sampled(imem_adr)));

    // cyc rises and falls with stb
    a_cyc_with_stb: assert property (@(posedge clk) disable iff (reset)
        imem_cyc == imem_stb)
        else stop_on_error($sformatf("mismatch %s cyc: expected %b actual %b",
                                     test_name, $sampled(imem_stb), $sampled(imem_cyc)));

    // every accepted address steps by 4
    a_adr_step: assert property (@(posedge clk) disable iff (reset)
        imem_stb && imem_ack |-> imem_adr == exp_adr)
        else stop_on_error($sformatf("mismatch %s fetch adr: expected %h actual %h",
                                     test_name, $sampled(exp_adr), $sampled(imem_adr)));
    // waiting request holds stb and adr
    a_wait_stable: assert property (@(posedge clk) disable iff (reset)
        imem_stb && !imem_ack |=> imem_stb && $stable(imem_adr))
        else stop_on_error($sformatf("mismatch %s stalled adr: expected %h actual %h",
                                     test_name, $sampled(last_adr), $sampled(imem_adr)));

    // commit order, timing, rd and data
    a_commit_valid: assert property (@(posedge clk) disable iff (reset)
        commit_valid == exp_valid)
        else stop_on_error($sformatf("mismatch %s commit_valid: expected %b actual %b",
                                     test_name, $sampled(exp_valid), $sampled(commit_valid)));
    a_commit_value: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> commit_rd == exp_rd && commit_data == exp_data)
        else stop_on_error($sformatf("mismatch %s commit: expected x%0d=%h actual x%0d=%h",
                                     test_name, $sampled(exp_rd), $sampled(exp_data),
                                     $sampled(commit_rd), $sampled(commit_data)));

    // balance flag after duplicate and original commits
    a_chk_after_dup: assert property (@(posedge clk) disable iff (reset)
        qed_mode && commit_valid && commit_rd[QED_SHADOW_BIT] |=> chk_en)
        else stop_on_error($sformatf("mismatch %s chk_en after duplicate: expected 1 actual %b",
                                     test_name, $sampled(chk_en)));
    a_chk_after_orig: assert property (@(posedge clk) disable iff (reset)
        qed_mode && commit_valid && commit_rd != '0 && !commit_rd[QED_SHADOW_BIT] |=> !chk_en)
        else stop_on_error($sformatf("mismatch %s chk_en after original: expected 0 actual %b",
                                     test_name, $sampled(chk_en)));

    // init words give every used register a known value first
    task automatic load_program(input int body_len, input int reg_limit, input bit bubbles);
        logic [4:0] prev_rd;
        int         r;
        int         n;
        prev_rd  = 5'd1;
        prog_len = 0;
        for (r = 1; r < reg_limit; r++) begin
            prog[prog_len] = i_type_word(12'($urandom), 5'd0, FUNCT3_ADD_SUB, 5'(r));
            prog_len++;
        end
        for (n = 0; n < body_len; n++) begin
            if (bubbles && $urandom % 3 == 0) begin
                prog[prog_len] = make_bubble(reg_limit);
            end else begin
                prog[prog_len] = pick_alu_inst(reg_limit, prev_rd);
                prev_rd        = prog[prog_len][11:7];
            end
            prog_len++;
        end
    endtask

    task automatic run_phase(input string name, input int body_len, input int reg_limit,
                             input bit bubbles, input bit qed);
        #1;
        reset     = 1'b1;
        qed_mode  = qed;
        test_name = "reset";
        load_program(body_len, reg_limit, bubbles);
        repeat (4) @(posedge clk);
        #1;
        reset     = 1'b0;
        test_name = name;
        while (accept_count < prog_len) begin
            @(posedge clk);
        end
        // last duplicate commits three edges after its accept
        repeat (4) @(posedge clk);
    endtask

    initial begin
        int r;
        void'($urandom(2));
        reset    = 1'b1;
        qed_mode = 1'b0;
        imem_ack = 1'b0;
        imem_dat = NOP_INST;
        for (r = 0; r < 32; r++) begin
            gold_regs[r] = '0;
        end
        run_phase("alu_random", ALU_BODY, 32, 1'b0, 1'b0);
        run_phase("bubbles", BUBBLE_BODY, 32, 1'b1, 1'b0);
        // qed program stays on x0..x15
        run_phase("qed", QED_BODY, 16, 1'b0, 1'b1);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
